// ==== lane_pkg.sv ====
package lane_pkg;

	//////////////////////////////////////////////////////////////////////
	// Lane geometry
	//////////////////////////////////////////////////////////////////////
	localparam int NUM_THREADS  = 4;
	localparam int WIDTH_THREAD = $clog2(NUM_THREADS);
	localparam int NUM_REGS     = 16;
	localparam int WIDTH_LREG   = $clog2(NUM_REGS);
	localparam int WIDTH_PREG   = WIDTH_THREAD + WIDTH_LREG;
	localparam int NUM_PREGS    = NUM_THREADS * NUM_REGS;
	localparam int WIDTH_DATA   = 32;
	localparam int WIDTH_IMM    = 16;

	typedef logic [WIDTH_DATA-1:0]   data_t;
	typedef logic [WIDTH_THREAD-1:0] thread_t;
	typedef logic [WIDTH_LREG-1:0]   lreg_t;
	typedef logic [WIDTH_PREG-1:0]   preg_t;
	typedef logic [WIDTH_IMM-1:0]    imm_t;

	// Opcodes as they appear in the command stream
	typedef enum logic [3:0] {
		NOP = 4'h0,
		LDI = 4'h1,
		ADD = 4'h2,
		SUB = 4'h3,
		MUL = 4'h4,
		AND = 4'h5,
		OR  = 4'h6,
		XOR = 4'h7,
		SLT = 4'h8,
		MOV = 4'h9,
		RD  = 4'hA
	} op_t;

	typedef struct packed {
		logic    valid;
		thread_t thread;
		op_t     op;
		lreg_t   dst;
		lreg_t   src1;
		lreg_t   src2;
		imm_t    imm;
		logic    masked;
	} cmd_t;

endpackage

// ==== wb_if.sv ====
`timescale 1ns/1ps

// Write-back bundle from the execute stage
interface wb_if
	import lane_pkg::*;
();
	logic  valid;
	preg_t dst;
	data_t data;
	logic  to_mask;

	// Execute side
	modport source (output valid, dst, data, to_mask);

	// Register bank, mask register and forwarding
	modport sink (input valid, dst, data, to_mask);

endinterface

// ==== index_unit.sv ====
`timescale 1ns/1ps

module index_unit
	import lane_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    hold,
	input  thread_t thread,
	input  lreg_t   src1,
	input  lreg_t   src2,
	input  lreg_t   dst,
	output preg_t   phys_src1,
	output preg_t   phys_src2,
	output preg_t   phys_dst
);

	preg_t map_src1;
	preg_t map_src2;
	preg_t map_dst;

	// Thread window base sits above the logical number
	assign map_src1 = {thread, src1};
	assign map_src2 = {thread, src2};
	assign map_dst  = {thread, dst};

	// Stage A register
	always_ff @(posedge clock) begin
		if (reset) begin
			phys_src1 <= '0;
			phys_src2 <= '0;
			phys_dst  <= '0;
		end else if (!hold) begin
			phys_src1 <= map_src1;
			phys_src2 <= map_src2;
			phys_dst  <= map_dst;
		end
	end

endmodule

// ==== reg_bank.sv ====
`timescale 1ns/1ps

module reg_bank
	import lane_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  preg_t rd_addr1,
	input  preg_t rd_addr2,
	output data_t rd_data1,
	output data_t rd_data2,
	input  logic  hold,
	wb_if.sink    wb
);

	data_t bank [NUM_PREGS];

	// Register write from the write-back bundle
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_PREGS; i++) begin
				bank[i] <= '0;
			end
		end else if (wb.valid && !wb.to_mask) begin
			bank[wb.dst] <= wb.data;
		end
	end

	// Two read ports return the old word on a same-edge write
	always_ff @(posedge clock) begin
		if (reset) begin
			rd_data1 <= '0;
			rd_data2 <= '0;
		end else if (!hold) begin
			rd_data1 <= bank[rd_addr1];
			rd_data2 <= bank[rd_addr2];
		end
	end

endmodule

// ==== mask_reg.sv ====
`timescale 1ns/1ps

module mask_reg
	import lane_pkg::*;
(
	input  logic                   clock,
	input  logic                   reset,
	wb_if.sink                     wb,
	input  thread_t                thread,
	output logic                   mask_bit,
	output logic [NUM_THREADS-1:0] mask
);

	thread_t wb_thread;
	logic    wb_set;

	// Owning thread comes from the window bits of the entry
	assign wb_thread = wb.dst[WIDTH_PREG-1 -: WIDTH_THREAD];
	assign wb_set    = wb.valid & wb.to_mask;

	always_ff @(posedge clock) begin
		if (reset) begin
			mask <= '0;
		end else if (wb_set) begin
			mask[wb_thread] <= wb.data[0];
		end
	end

	// Pending compare result wins over the stored bit
	assign mask_bit = (wb_set && wb_thread == thread) ? wb.data[0] : mask[thread];

endmodule

// ==== exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit
	import lane_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  hold,
	input  cmd_t  cmd,
	input  preg_t phys_dst,
	input  data_t opnd1,
	input  data_t opnd2,
	input  logic  mask_bit,
	wb_if.source  wb,
	output logic  commit,
	output data_t result
);

	data_t alu_out;
	data_t imm_ext;
	logic  issue;
	logic  write_ok;
	logic  commit_q;

	assign imm_ext = {{(WIDTH_DATA-WIDTH_IMM){cmd.imm[WIDTH_IMM-1]}}, cmd.imm};

	//////////////////////////////////////////////////////////////////////
	// Integer datapath
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (cmd.op)
			LDI:     alu_out = imm_ext;
			ADD:     alu_out = opnd1 + opnd2;
			SUB:     alu_out = opnd1 - opnd2;
			MUL:     alu_out = data_t'(opnd1 * opnd2);
			AND:     alu_out = opnd1 & opnd2;
			OR:      alu_out = opnd1 | opnd2;
			XOR:     alu_out = opnd1 ^ opnd2;
			SLT:     alu_out = ($signed(opnd1) < $signed(opnd2)) ? 32'd1 : 32'd0;
			MOV:     alu_out = opnd1;
			RD:      alu_out = opnd1;
			default: alu_out = '0;
		endcase
	end

	// Every real command commits
	assign issue = cmd.valid && (cmd.op != NOP);

	// Masked commands with a clear bit still commit but skip write-back
	assign write_ok = issue && (cmd.op != RD) && !(cmd.masked && !mask_bit);

	//////////////////////////////////////////////////////////////////////
	// Stage C registers
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			commit_q <= 1'b0;
			wb.valid <= 1'b0;
		end else if (!hold) begin
			commit_q <= issue;
			wb.valid <= write_ok;
		end
	end

	always_ff @(posedge clock) begin
		if (!hold) begin
			result     <= alu_out;
			wb.dst     <= phys_dst;
			wb.data    <= alu_out;
			wb.to_mask <= (cmd.op == SLT);
		end
	end

	// A held commit shows once, in the first enabled cycle
	assign commit = commit_q & ~hold;

endmodule

// ==== lane_unit.sv ====
`timescale 1ns/1ps

module lane_unit
	import lane_pkg::*;
(
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   en,
	input  logic                   cmd_valid,
	input  thread_t                thread,
	input  op_t                    op,
	input  lreg_t                  dst,
	input  lreg_t                  src1,
	input  lreg_t                  src2,
	input  imm_t                   imm,
	input  logic                   masked,
	output logic                   commit,
	output data_t                  result,
	output logic [NUM_THREADS-1:0] mask
);

	logic  hold;
	cmd_t  cmd_in;
	cmd_t  cmd_a;
	cmd_t  cmd_b;
	preg_t phys_src1;
	preg_t phys_src2;
	preg_t phys_dst;
	preg_t src1_b;
	preg_t src2_b;
	preg_t dst_b;
	data_t rd_data1;
	data_t rd_data2;
	data_t opnd1;
	data_t opnd2;
	logic  mask_bit;

	logic  last_valid;
	preg_t last_dst;
	data_t last_data;
	logic  hit_wb1;
	logic  hit_wb2;
	logic  hit_last1;
	logic  hit_last2;

	wb_if wb_bus ();

	// Lane enable is a plain level
	assign hold = ~en;

	//////////////////////////////////////////////////////////////////////
	// Stage A command capture
	//////////////////////////////////////////////////////////////////////
	assign cmd_in.valid  = cmd_valid;
	assign cmd_in.thread = thread;
	assign cmd_in.op     = op;
	assign cmd_in.dst    = dst;
	assign cmd_in.src1   = src1;
	assign cmd_in.src2   = src2;
	assign cmd_in.imm    = imm;
	assign cmd_in.masked = masked;

	always_ff @(posedge clock) begin
		if (reset) begin
			cmd_a <= '0;
			cmd_b <= '0;
		end else if (!hold) begin
			cmd_a <= cmd_in;
			cmd_b <= cmd_a;
		end
	end

	index_unit u_index (
		.clock     (clock),
		.reset     (reset),
		.hold      (hold),
		.thread    (thread),
		.src1      (src1),
		.src2      (src2),
		.dst       (dst),
		.phys_src1 (phys_src1),
		.phys_src2 (phys_src2),
		.phys_dst  (phys_dst)
	);

	// Stage B entries travel beside the bank read
	always_ff @(posedge clock) begin
		if (!hold) begin
			src1_b <= phys_src1;
			src2_b <= phys_src2;
			dst_b  <= phys_dst;
		end
	end

	reg_bank u_bank (
		.clock    (clock),
		.reset    (reset),
		.rd_addr1 (phys_src1),
		.rd_addr2 (phys_src2),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2),
		.hold     (hold),
		.wb       (wb_bus.sink)
	);

	//////////////////////////////////////////////////////////////////////
	// Operand forwarding
	//////////////////////////////////////////////////////////////////////
	// Bank read on the write edge returns the old word
	// so the last written bundle stays around one more step
	always_ff @(posedge clock) begin
		if (reset) begin
			last_valid <= 1'b0;
		end else if (!hold) begin
			last_valid <= wb_bus.valid & ~wb_bus.to_mask;
		end
	end

	always_ff @(posedge clock) begin
		if (!hold) begin
			last_dst  <= wb_bus.dst;
			last_data <= wb_bus.data;
		end
	end

	assign hit_wb1   = wb_bus.valid & ~wb_bus.to_mask & (wb_bus.dst == src1_b);
	assign hit_wb2   = wb_bus.valid & ~wb_bus.to_mask & (wb_bus.dst == src2_b);
	assign hit_last1 = last_valid & (last_dst == src1_b);
	assign hit_last2 = last_valid & (last_dst == src2_b);

	// Newest result first
	assign opnd1 = hit_wb1 ? wb_bus.data : (hit_last1 ? last_data : rd_data1);
	assign opnd2 = hit_wb2 ? wb_bus.data : (hit_last2 ? last_data : rd_data2);

	mask_reg u_mask (
		.clock    (clock),
		.reset    (reset),
		.wb       (wb_bus.sink),
		.thread   (cmd_b.thread),
		.mask_bit (mask_bit),
		.mask     (mask)
	);

	exec_unit u_exec (
		.clock    (clock),
		.reset    (reset),
		.hold     (hold),
		.cmd      (cmd_b),
		.phys_dst (dst_b),
		.opnd1    (opnd1),
		.opnd2    (opnd2),
		.mask_bit (mask_bit),
		.wb       (wb_bus.source),
		.commit   (commit),
		.result   (result)
	);

endmodule

// ==== lane_chk.sv ====
`timescale 1ns/1ps

module lane_chk
	import lane_pkg::*;
(
	input logic  clock,
	input logic  reset,
	input logic  en,
	input logic  commit,
	input data_t result
);

	// Quiet during reset and in the first cycle out of it
	a_reset_quiet: assert property (@(posedge clock) reset |-> !commit)
		else $error("commit high while reset is asserted");

	a_after_reset: assert property (@(posedge clock) $fell(reset) |-> !commit)
		else $error("commit high in the cycle after reset");

	// A stalled lane shows nothing
	a_stall_quiet: assert property (@(posedge clock) !en |-> !commit)
		else $error("commit high while en is low");

	a_result_known: assert property (@(posedge clock) disable iff (reset)
		commit |-> !$isunknown(result))
		else $error("result unknown during commit");

endmodule

// ==== tb_lane.sv ====
`timescale 1ns/1ps

module tb_lane
	import lane_pkg::*;
();

	typedef struct packed {
		thread_t thread;
		op_t     op;
		lreg_t   dst;
		lreg_t   src1;
		lreg_t   src2;
		imm_t    imm;
		logic    masked;
		data_t   expected;
	} vec_t;

	logic                   clock;
	logic                   reset;
	logic                   en;
	logic                   cmd_valid;
	thread_t                thread;
	op_t                    op;
	lreg_t                  dst;
	lreg_t                  src1;
	lreg_t                  src2;
	imm_t                   imm;
	logic                   masked;
	logic                   commit;
	data_t                  result;
	logic [NUM_THREADS-1:0] mask;

	vec_t                   vecs[$];
	data_t                  exp_q[$];
	data_t                  exp_res;
	logic [NUM_THREADS-1:0] exp_mask;
	int                     cycle_count = 0;
	int                     cycle_limit = 0;
	int                     expect_count;
	int                     commit_count;
	int                     result_errors;
	int                     other_errors;
	logic                   timed_out;

	lane_unit UUT (
		.clock     (clock),
		.reset     (reset),
		.en        (en),
		.cmd_valid (cmd_valid),
		.thread    (thread),
		.op        (op),
		.dst       (dst),
		.src1      (src1),
		.src2      (src2),
		.imm       (imm),
		.masked    (masked),
		.commit    (commit),
		.result    (result),
		.mask      (mask)
	);

	bind lane_unit lane_chk u_chk (
		.clock  (clock),
		.reset  (reset),
		.en     (en),
		.commit (commit),
		.result (result)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
	end

	//////////////////////////////////////////////////////////////////////
	// Vector file
	//////////////////////////////////////////////////////////////////////
	task automatic load_vectors();
		int          fd;
		string       line;
		logic [31:0] f_thread, f_op, f_dst, f_src1, f_src2, f_imm, f_masked, f_exp;
		vec_t        v;
		fd = $fopen("lane_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open lane_input.txt");
			other_errors++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			// Final line holds the expected mask vector
			if (line.getc(0) == "m") begin
				if ($sscanf(line, "mask %h", f_exp) != 1) begin
					$display("Malformed mask line in lane_input.txt");
					other_errors++;
				end
				exp_mask = f_exp[NUM_THREADS-1:0];
				continue;
			end
			if ($sscanf(line, "%h %h %h %h %h %h %h %h", f_thread, f_op, f_dst,
					f_src1, f_src2, f_imm, f_masked, f_exp) != 8) begin
				$display("Malformed vector line in lane_input.txt");
				other_errors++;
				continue;
			end
			v.thread   = f_thread[WIDTH_THREAD-1:0];
			v.op       = op_t'(f_op[3:0]);
			v.dst      = f_dst[WIDTH_LREG-1:0];
			v.src1     = f_src1[WIDTH_LREG-1:0];
			v.src2     = f_src2[WIDTH_LREG-1:0];
			v.imm      = f_imm[WIDTH_IMM-1:0];
			v.masked   = f_masked[0];
			v.expected = f_exp;
			vecs.push_back(v);
		end
		$fclose(fd);
	endtask

	// Present one command, dropping en on random cycles first
	task automatic send_vector(input vec_t v);
		logic sent;
		sent = 1'b0;
		while (!sent && cycle_count < cycle_limit) begin
			@(posedge clock);
			if (($urandom % 32'd6) == 32'd0) begin
				en <= 1'b0;
			end else begin
				en        <= 1'b1;
				cmd_valid <= 1'b1;
				thread    <= v.thread;
				op        <= v.op;
				dst       <= v.dst;
				src1      <= v.src1;
				src2      <= v.src2;
				imm       <= v.imm;
				masked    <= v.masked;
				if (v.op != NOP) begin
					exp_q.push_back(v.expected);
				end
				sent = 1'b1;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Commit monitor
	//////////////////////////////////////////////////////////////////////
	always @(negedge clock) begin
		if (!reset && commit) begin
			if (!en) begin
				$display("Commit seen while the lane enable was low");
				other_errors++;
			end
			if (exp_q.size() == 0) begin
				$display("Commit arrived with no command pending");
				other_errors++;
			end else begin
				exp_res = exp_q.pop_front();
				commit_count++;
				if (result !== exp_res) begin
					$display("CHECK FAILED result: expected %08h, actual %08h (commit %0d)",
						exp_res, result, commit_count);
					result_errors++;
				end
			end
		end
	end

	initial begin
		reset         = 1'b1;
		en            = 1'b0;
		cmd_valid     = 1'b0;
		thread        = '0;
		op            = NOP;
		dst           = '0;
		src1          = '0;
		src2          = '0;
		imm           = '0;
		masked        = 1'b0;
		exp_mask      = '0;
		expect_count  = 0;
		commit_count  = 0;
		result_errors = 0;
		other_errors  = 0;
		timed_out     = 1'b0;
		void'($urandom(25));

		load_vectors();
		if (vecs.size() == 0) begin
			$display("No command vectors were read");
			other_errors++;
		end
		cycle_limit = vecs.size() * 4 + 50;
		foreach (vecs[i]) begin
			if (vecs[i].op != NOP) begin
				expect_count++;
			end
		end

		// Lane enabled while still in reset
		@(posedge clock);
		en <= 1'b1;
		@(posedge clock);
		reset <= 1'b0;

		foreach (vecs[i]) begin
			send_vector(vecs[i]);
		end
		@(posedge clock);
		en        <= 1'b1;
		cmd_valid <= 1'b0;
		op        <= NOP;

		// Drain until every command has committed
		while (commit_count < expect_count && !timed_out) begin
			@(posedge clock);
			if (cycle_count >= cycle_limit) begin
				timed_out = 1'b1;
			end
		end

		if (timed_out) begin
			$display("Timeout: commits never arrived, %0d of %0d seen after %0d cycles",
				commit_count, expect_count, cycle_count);
			other_errors++;
		end else begin
			// Last compare result lands one edge after its commit
			repeat (4) @(posedge clock);
			@(negedge clock);
			if (mask !== exp_mask) begin
				$display("CHECK FAILED mask: expected %01h, actual %01h", exp_mask, mask);
				result_errors++;
			end
		end

		$display("Errors: %0d value mismatches, %0d other failures, %0d of %0d commits",
			result_errors, other_errors, commit_count, expect_count);
		if (result_errors == 0 && other_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== lane_input.txt ====
# thread op dst src1 src2 imm masked expected, all hex; last line is the final mask
# op: 0 NOP, 1 LDI, 2 ADD, 3 SUB, 4 MUL, 5 AND, 6 OR, 7 XOR, 8 SLT, 9 MOV, A RD
0 1 1 0 0 0005 0 00000005
1 1 1 0 0 0007 0 00000007
2 1 1 0 0 FFFD 0 FFFFFFFD
3 1 1 0 0 1234 0 00001234
0 1 2 0 0 0003 0 00000003
1 1 2 0 0 0010 0 00000010
2 1 2 0 0 0004 0 00000004
3 1 2 0 0 00FF 0 000000FF
0 2 3 1 2 0000 0 00000008
1 3 3 1 2 0000 0 FFFFFFF7
2 4 3 1 2 0000 0 FFFFFFF4
3 5 3 1 2 0000 0 00000034
0 6 4 1 2 0000 0 00000007
1 7 4 1 2 0000 0 00000017
# dependent chain in thread 0
0 2 5 3 3 0000 0 00000010
0 4 5 5 4 0000 0 00000070
0 3 6 5 1 0000 0 0000006B
0 2 6 6 5 0000 0 000000DB
0 9 7 6 0 0000 0 000000DB
0 0 0 0 0 0000 0 00000000
# reads leave registers untouched
2 A 1 3 0 0000 0 FFFFFFF4
2 A 1 1 0 0000 0 FFFFFFFD
0 A 0 1 0 0000 0 00000005
1 A 0 1 0 0000 0 00000007
3 A 0 1 0 0000 0 00001234
# compares and masked writes
1 8 0 1 2 0000 0 00000001
2 8 0 2 1 0000 0 00000000
2 9 2 3 0 0000 1 FFFFFFF4
2 A 0 2 0 0000 0 00000004
1 9 5 3 0 0000 1 FFFFFFF7
1 A 0 5 0 0000 0 FFFFFFF7
0 8 0 1 2 0000 0 00000000
0 8 0 2 1 0000 0 00000001
0 2 8 1 2 0000 1 00000008
0 A 0 8 0 0000 0 00000008
3 8 0 2 1 0000 0 00000001
3 8 0 1 2 0000 0 00000000
3 9 4 1 0 0000 1 00001234
3 A 0 4 0 0000 0 00000000
0 0 0 0 0 0000 0 00000000
2 7 9 1 2 0000 0 FFFFFFF9
2 A 0 9 0 0000 0 FFFFFFF9
mask 3

// ==== src.f ====
lane_pkg.sv
wb_if.sv
index_unit.sv
reg_bank.sv
mask_reg.sv
exec_unit.sv
lane_unit.sv
lane_chk.sv
tb_lane.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the lane testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_lane -f src.f -o tb_lane_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/tb_lane_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Test completed successfully" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
